//--- logic/i2c_rx_pkg.sv
// i2c_rx_pkg: data widths, command and result structs, bus timing constants
package i2c_rx_pkg;

  // synchronizer depth on the scl and sda inputs
  localparam int unsigned SyncStages = 2;

  // scl high cycles before an sda rise is taken as a stop condition
  localparam int unsigned StopHoldCycles = 4;

  // one received data value
  typedef logic [7:0] rx_byte_t;

  // bytes per command, 1 to 15
  typedef logic [3:0] byte_count_t;

  // stable-high counter, saturates at StopHoldCycles
  typedef logic [2:0] hold_count_t;

  typedef enum logic {
    RxReadBytes = 1'b0,
    RxReadBit   = 1'b1
  } rx_kind_e;

  // host command, count is ignored for a bit read
  typedef struct packed {
    rx_kind_e    kind;
    byte_count_t count;
  } rx_cmd_t;

  // one result per byte or bit
  typedef struct packed {
    rx_byte_t data;
    logic     is_bit;   // data holds a single bit in the lsb
    logic     last;     // final result of the command
    logic     aborted;  // a stop ended the command
  } rx_rsp_t;

endpackage

//--- logic/bus_line_sampler.sv
// bus_line_sampler: scl/sda synchronizers, scl rising edge, stable-high tracking, stop detect
`timescale 1ns/10ps

module bus_line_sampler (
  input  logic clk_i,
  input  logic rst_ni,

  input  logic scl_i,
  input  logic sda_i,

  output logic scl_posedge_o,
  output logic scl_stable_high_o,
  output logic sda_o,
  output logic stop_det_o
);
  import i2c_rx_pkg::*;

  logic [SyncStages-1:0] scl_sync_q;
  logic [SyncStages-1:0] sda_sync_q;
  logic                  scl_q;          // one stage behind the synchronizer
  logic                  sda_q;
  logic                  sda_prev_q;
  logic                  scl_posedge_q;
  hold_count_t           hold_q;

  // lines idle high, so reset to high avoids a false edge after reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_sync_q    <= '1;
      sda_sync_q    <= '1;
      scl_q         <= 1'b1;
      sda_q         <= 1'b1;
      sda_prev_q    <= 1'b1;
      scl_posedge_q <= 1'b0;
    end else begin
      scl_sync_q    <= {scl_sync_q[SyncStages-2:0], scl_i};
      sda_sync_q    <= {sda_sync_q[SyncStages-2:0], sda_i};
      scl_q         <= scl_sync_q[SyncStages-1];
      sda_q         <= sda_sync_q[SyncStages-1];
      sda_prev_q    <= sda_q;
      scl_posedge_q <= scl_sync_q[SyncStages-1] & ~scl_q;
    end
  end

  // count scl high cycles up to the stop hold limit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_q <= '0;
    end else if (!scl_q) begin
      hold_q <= '0;
    end else if (!scl_stable_high_o) begin
      hold_q <= hold_q + 1'b1;
    end
  end

  assign scl_stable_high_o = (hold_q == hold_count_t'(StopHoldCycles));
  assign scl_posedge_o     = scl_posedge_q;  // aligned with sda_o
  assign sda_o             = sda_q;

  // sda rising while scl has been high long enough
  assign stop_det_o = sda_q & ~sda_prev_q & scl_stable_high_o;

endmodule

//--- logic/bus_rx_flow.sv
// bus_rx_flow: state machine that shifts in one bit or one byte per request
`timescale 1ns/10ps

module bus_rx_flow (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  input  logic                 scl_posedge_i,
  input  logic                 scl_stable_high_i,  // shared with the other flows, unused here
  input  logic                 sda_i,

  input  logic                 rx_req_bit_i,
  input  logic                 rx_req_byte_i,
  output i2c_rx_pkg::rx_byte_t rx_data_o,
  output logic                 rx_done_o,
  output logic                 rx_idle_o,
  output logic                 error_o
);
  import i2c_rx_pkg::*;

  typedef enum logic [1:0] {
    Idle,
    ReadByte,
    ReadBit,
    NextTaskDecision
  } rx_state_e;

  rx_state_e state_d;
  rx_state_e state_q;

  logic       req;
  logic       rx_req_bit_q;
  logic       sample_en;
  logic       cnt_en;
  logic       bit_valid_q;   // a bit was sampled on the last scl edge
  logic       bit_q;
  logic [2:0] bit_cnt_q;
  logic [6:0] shift_q;

  assign req     = rx_req_bit_i | rx_req_byte_i;
  assign error_o = rx_req_bit_i & rx_req_byte_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rx_req_bit_q <= 1'b0;
    end else begin
      rx_req_bit_q <= rx_req_bit_i;
    end
  end

  // sample sda on a rising scl edge, valid for one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bit_valid_q <= 1'b0;
    end else begin
      bit_valid_q <= sample_en & scl_posedge_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (sample_en && scl_posedge_i) begin
      bit_q <= sda_i;
    end
  end

  // bits left in the current byte, counts down from seven
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bit_cnt_q <= 3'd7;
    end else if (!cnt_en) begin
      bit_cnt_q <= 3'd7;
    end else if (bit_valid_q && bit_cnt_q != 3'd0) begin
      bit_cnt_q <= bit_cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cnt_en && bit_valid_q) begin
      shift_q <= {shift_q[5:0], bit_q};  // msb first
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    rx_idle_o = 1'b0;
    rx_done_o = 1'b0;
    rx_data_o = '0;
    sample_en = 1'b0;
    cnt_en    = 1'b0;

    unique case (state_q)
      Idle: begin
        rx_idle_o = 1'b1;
      end
      ReadByte: begin
        cnt_en    = 1'b1;
        sample_en = ~bit_valid_q;
        if (bit_valid_q && bit_cnt_q == 3'd0) begin
          rx_done_o = 1'b1;
          rx_data_o = {shift_q, bit_q};
        end
      end
      ReadBit: begin
        sample_en = ~bit_valid_q;
        if (bit_valid_q) begin
          rx_done_o = 1'b1;
          rx_data_o = {7'b0, bit_q};  // single bit in the lsb
        end
      end
      NextTaskDecision: begin
        sample_en = req;  // do not miss an edge while deciding
      end
      default: ;
    endcase
  end

  always_comb begin
    state_d = state_q;

    unique case (state_q)
      Idle: begin
        state_d = rx_req_byte_i ? ReadByte : rx_req_bit_q ? ReadBit : Idle;
      end
      ReadByte: begin
        if (rx_done_o) begin
          state_d = NextTaskDecision;
        end
      end
      ReadBit: begin
        if (bit_valid_q) begin
          state_d = NextTaskDecision;
        end
      end
      NextTaskDecision: begin
        state_d = rx_req_byte_i ? ReadByte : rx_req_bit_q ? ReadBit : Idle;
      end
      default: begin
        state_d = Idle;
      end
    endcase

    // requests dropped or conflicting, back to idle
    if (!req || error_o) begin
      state_d = Idle;
    end
  end

endmodule

//--- logic/rx_sequencer.sv
// rx_sequencer: command intake, request hold, byte counting, stop abort and result strobes
`timescale 1ns/10ps

module rx_sequencer (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  input  logic                 cmd_valid_i,
  input  i2c_rx_pkg::rx_cmd_t  cmd_i,
  input  logic                 stop_det_i,

  input  i2c_rx_pkg::rx_byte_t rx_data_i,
  input  logic                 rx_done_i,
  input  logic                 rx_idle_i,
  input  logic                 rx_error_i,

  output logic                 req_bit_o,
  output logic                 req_byte_o,
  output logic                 rsp_valid_o,
  output i2c_rx_pkg::rx_rsp_t  rsp_o,
  output logic                 busy_o,
  output logic                 proto_error_o
);
  import i2c_rx_pkg::*;

  typedef enum logic [1:0] {
    Ready,
    Reading,
    Draining
  } seq_state_e;

  seq_state_e  state_q;
  rx_kind_e    kind_q;
  byte_count_t remaining_q;
  logic        rsp_valid_q;
  rx_rsp_t     rsp_q;
  logic        error_q;
  logic        is_last;

  assign is_last = (kind_q == RxReadBit) || (remaining_q <= byte_count_t'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= Ready;
      rsp_valid_q <= 1'b0;
      error_q     <= 1'b0;
    end else begin
      rsp_valid_q <= 1'b0;
      error_q     <= error_q | rx_error_i;  // sticky until reset
      unique case (state_q)
        Ready: begin
          if (cmd_valid_i) begin
            state_q <= Reading;
          end
        end
        Reading: begin
          if (stop_det_i) begin
            state_q <= Draining;  // request drops, result follows once flow is idle
          end else if (rx_done_i) begin
            rsp_valid_q <= 1'b1;
            if (is_last) begin
              state_q <= Ready;
            end
          end
        end
        Draining: begin
          if (rx_idle_i) begin
            rsp_valid_q <= 1'b1;
            state_q     <= Ready;
          end
        end
        default: state_q <= Ready;
      endcase
    end
  end

  // command and result payload
  always_ff @(posedge clk_i) begin
    if (state_q == Ready && cmd_valid_i) begin
      kind_q      <= cmd_i.kind;
      remaining_q <= cmd_i.count;
    end else if (state_q == Reading && !stop_det_i && rx_done_i) begin
      remaining_q <= remaining_q - 1'b1;
      rsp_q       <= '{data: rx_data_i, is_bit: kind_q == RxReadBit, last: is_last,
                       aborted: 1'b0};
    end else if (state_q == Draining) begin
      rsp_q <= '{data: '0, is_bit: kind_q == RxReadBit, last: 1'b1, aborted: 1'b1};
    end
  end

  assign req_byte_o    = (state_q == Reading) && (kind_q == RxReadBytes);
  assign req_bit_o     = (state_q == Reading) && (kind_q == RxReadBit);
  assign busy_o        = (state_q != Ready);
  assign rsp_valid_o   = rsp_valid_q;
  assign rsp_o         = rsp_q;
  assign proto_error_o = error_q;

endmodule

//--- logic/i2c_rx_top.sv
// i2c_rx_top: bus line sampler, receive flow and command sequencer
`timescale 1ns/10ps

module i2c_rx_top (
  input  logic                clk_i,
  input  logic                rst_ni,

  input  logic                scl_i,
  input  logic                sda_i,

  input  logic                cmd_valid_i,
  input  i2c_rx_pkg::rx_cmd_t cmd_i,

  output logic                rsp_valid_o,
  output i2c_rx_pkg::rx_rsp_t rsp_o,

  output logic                busy_o,
  output logic                proto_error_o
);
  import i2c_rx_pkg::*;

  logic     scl_posedge;
  logic     scl_stable_high;
  logic     sda;
  logic     stop_det;
  logic     req_bit;
  logic     req_byte;
  rx_byte_t rx_data;
  logic     rx_done;
  logic     rx_idle;
  logic     rx_error;

  bus_line_sampler i_bus_line_sampler (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .scl_i             (scl_i),
    .sda_i             (sda_i),
    .scl_posedge_o     (scl_posedge),
    .scl_stable_high_o (scl_stable_high),
    .sda_o             (sda),
    .stop_det_o        (stop_det)
  );

  bus_rx_flow i_bus_rx_flow (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .scl_posedge_i     (scl_posedge),
    .scl_stable_high_i (scl_stable_high),
    .sda_i             (sda),
    .rx_req_bit_i      (req_bit),
    .rx_req_byte_i     (req_byte),
    .rx_data_o         (rx_data),
    .rx_done_o         (rx_done),
    .rx_idle_o         (rx_idle),
    .error_o           (rx_error)
  );

  rx_sequencer i_rx_sequencer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_i         (cmd_i),
    .stop_det_i    (stop_det),
    .rx_data_i     (rx_data),
    .rx_done_i     (rx_done),
    .rx_idle_i     (rx_idle),
    .rx_error_i    (rx_error),
    .req_bit_o     (req_bit),
    .req_byte_o    (req_byte),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_o         (rsp_o),
    .busy_o        (busy_o),
    .proto_error_o (proto_error_o)
  );

endmodule

//--- testbench/i2c_rx_sva.sv
// i2c_rx_sva: concurrent assertions on the i2c_rx_top result strobe, busy and error flag
`timescale 1ns/10ps

module i2c_rx_sva (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                rsp_valid_i,
  input i2c_rx_pkg::rx_rsp_t rsp_i,
  input logic                busy_i,
  input logic                proto_error_i
);
  int unsigned fail_cnt = 0;  // summed into the testbench totals

  rsp_single_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_i |=> !rsp_valid_i)
    else begin
      $error("rsp_valid_o high two cycles in a row");
      fail_cnt++;
    end

  no_proto_error: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !proto_error_i)
    else begin
      $error("proto_error_o raised");
      fail_cnt++;
    end

  // busy ends only with the final result of a command
  busy_ends_on_last: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(busy_i) |-> rsp_valid_i && rsp_i.last)
    else begin
      $error("busy_o fell without a last result");
      fail_cnt++;
    end

endmodule

bind i2c_rx_top i2c_rx_sva i_i2c_rx_sva (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .rsp_valid_i   (rsp_valid_o),
  .rsp_i         (rsp_o),
  .busy_i        (busy_o),
  .proto_error_i (proto_error_o)
);

//--- testbench/i2c_rx_tb.sv
// i2c_rx_tb: directed tests with a bus model, command tasks, compare tasks and a watchdog
`timescale 1ns/10ps

module i2c_rx_tb;
  import i2c_rx_pkg::*;

  // bus bits driven by all tests, plus about three bits of framing per transfer
  localparam int unsigned TotalBusBits  = 8 + 8 + 40 + 2 + 11 + 16 + 8 * 3;
  localparam int unsigned TimeoutCycles = 2 * TotalBusBits * 16;

  logic        clk_i;
  logic        rst_ni;
  logic        scl_i;
  logic        sda_i;
  logic        cmd_valid_i;
  rx_cmd_t     cmd_i;
  logic        rsp_valid_o;
  rx_rsp_t     rsp_o;
  logic        busy_o;
  logic        proto_error_o;

  rx_rsp_t     rsp_q[$];  // results seen on the dut
  rx_byte_t    exp_q[$];  // values driven on the bus, in order
  string       test_name;
  int unsigned cycle_cnt = 0;
  int unsigned n_checks = 0;
  int unsigned n_errors = 0;
  int unsigned n_tests = 0;
  int unsigned test_err_base;

  i2c_rx_top i_i2c_rx_top (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .scl_i         (scl_i),
    .sda_i         (sda_i),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_i         (cmd_i),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_o         (rsp_o),
    .busy_o        (busy_o),
    .proto_error_o (proto_error_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  initial begin
    wait (cycle_cnt >= TimeoutCycles);
    $display("timeout after %0d cycles, test %s did not finish", cycle_cnt, test_name);
    $display("Errors found");
    $finish;
  end

  always @(negedge clk_i) begin
    if (rsp_valid_o) rsp_q.push_back(rsp_o);  // mid-cycle, outputs are settled
  end

  task automatic clocks(input int unsigned n);
    repeat (n) @(posedge clk_i);
    #10;
  endtask

  task automatic bus_start();
    sda_i = 1'b0;  // sda falls while scl is high
    clocks(4);
    scl_i = 1'b0;
  endtask

  task automatic bus_bit(input logic b);
    clocks(4);
    sda_i = b;  // middle of scl low
    clocks(4);
    scl_i = 1'b1;
    clocks(8);
    scl_i = 1'b0;
  endtask

  task automatic bus_stop();
    clocks(4);
    sda_i = 1'b0;
    clocks(4);
    scl_i = 1'b1;
    clocks(4);
    sda_i = 1'b1;  // middle of scl high, scl stays high
    clocks(8);
  endtask

  task automatic drive_random_bytes(input int unsigned n);
    rx_byte_t b;
    repeat (n) begin
      b = rx_byte_t'($urandom);
      exp_q.push_back(b);
      for (int i = 7; i >= 0; i--) bus_bit(b[i]);  // msb first
    end
  endtask

  task automatic send_cmd(input rx_kind_e kind, input byte_count_t count);
    cmd_valid_i = 1'b1;
    cmd_i       = '{kind: kind, count: count};
    clocks(1);
    cmd_valid_i = 1'b0;
    cmd_i       = '0;
  endtask

  task automatic wait_idle();
    int unsigned waited;
    waited = 0;
    while (busy_o && waited < 64) begin
      clocks(1);
      waited++;
    end
    if (busy_o) begin
      $display("%s: busy_o stayed high after the bus transfer ended", test_name);
      n_errors++;
    end
    clocks(4);  // room for a stray strobe
  endtask

  task automatic check_byte(input string what, input rx_byte_t exp, input rx_byte_t act);
    n_checks++;
    if (act !== exp) begin
      $display("CHECK FAILED %s %s: expected %02h actual %02h", test_name, what, exp, act);
      n_errors++;
    end
  endtask

  task automatic check_rsp_flags(input string what, input rx_rsp_t exp, input rx_rsp_t act);
    n_checks++;
    if ({act.is_bit, act.last, act.aborted} !== {exp.is_bit, exp.last, exp.aborted}) begin
      $display("CHECK FAILED %s %s: expected is_bit/last/aborted %b%b%b actual %b%b%b",
               test_name, what, exp.is_bit, exp.last, exp.aborted,
               act.is_bit, act.last, act.aborted);
      n_errors++;
    end
  endtask

  task automatic check_level(input string what, input logic exp, input logic act);
    n_checks++;
    if (act !== exp) begin
      $display("CHECK FAILED %s %s: expected %b actual %b", test_name, what, exp, act);
      n_errors++;
    end
  endtask

  // every driven value gives one result, last only on the final one
  task automatic check_results(input logic is_bit, input logic aborted);
    rx_rsp_t exp;
    if (rsp_q.size() != exp_q.size()) begin
      $display("%s: expected %0d result strobes but saw %0d", test_name, exp_q.size(),
               rsp_q.size());
      n_errors++;
    end
    for (int i = 0; i < exp_q.size() && i < rsp_q.size(); i++) begin
      exp = '{data: exp_q[i], is_bit: is_bit, last: i == exp_q.size() - 1, aborted: aborted};
      check_byte($sformatf("data[%0d]", i), exp.data, rsp_q[i].data);
      check_rsp_flags($sformatf("flags[%0d]", i), exp, rsp_q[i]);
    end
  endtask

  task automatic start_test(input string name);
    test_name     = name;
    test_err_base = n_errors;
    n_tests++;
    rsp_q.delete();
    exp_q.delete();
  endtask

  task automatic end_test();
    $display("test %s finished, %0d failures", test_name, n_errors - test_err_base);
  endtask

  task automatic test_reset_idle();
    start_test("reset_idle");
    check_level("busy_o", 1'b0, busy_o);
    check_level("rsp_valid_o", 1'b0, rsp_valid_o);
    check_level("proto_error_o", 1'b0, proto_error_o);
    bus_start();
    drive_random_bytes(1);  // no command, nothing may come back
    bus_stop();
    clocks(4);
    exp_q.delete();
    check_results(1'b0, 1'b0);
    end_test();
  endtask

  task automatic test_read_bytes(input string name, input byte_count_t count);
    start_test(name);
    bus_start();
    send_cmd(RxReadBytes, count);
    drive_random_bytes(count);
    bus_stop();
    wait_idle();
    check_results(1'b0, 1'b0);
    check_level("busy_o", 1'b0, busy_o);
    end_test();
  endtask

  task automatic test_read_bit(input logic b);
    start_test(b ? "read_bit_one" : "read_bit_zero");
    bus_start();
    send_cmd(RxReadBit, '0);
    exp_q.push_back({7'b0, b});
    bus_bit(b);
    bus_stop();
    wait_idle();
    check_results(1'b1, 1'b0);
    end_test();
  endtask

  task automatic test_stop_abort();
    start_test("stop_abort");
    bus_start();
    send_cmd(RxReadBytes, 4'd2);
    bus_bit(1'b1);
    bus_bit(1'b0);
    bus_bit(1'b1);
    bus_stop();
    wait_idle();
    exp_q.push_back('0);
    check_results(1'b0, 1'b1);
    rsp_q.delete();
    exp_q.delete();
    bus_start();
    send_cmd(RxReadBytes, 4'd1);
    drive_random_bytes(1);
    bus_stop();
    wait_idle();
    check_results(1'b0, 1'b0);
    end_test();
  endtask

  task automatic test_busy_ignore();
    start_test("busy_ignore");
    bus_start();
    send_cmd(RxReadBytes, 4'd2);
    check_level("busy_o", 1'b1, busy_o);
    send_cmd(RxReadBytes, 4'd3);  // lands while busy
    drive_random_bytes(2);
    bus_stop();
    wait_idle();
    check_results(1'b0, 1'b0);
    end_test();
  endtask

  initial begin
    void'($urandom(9));
    rst_ni      = 1'b0;
    scl_i       = 1'b1;
    sda_i       = 1'b1;
    cmd_valid_i = 1'b0;
    cmd_i       = '0;
    test_name   = "reset";
    repeat (10) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    clocks(2);

    test_reset_idle();
    test_read_bytes("single_byte", 4'd1);
    test_read_bytes("five_bytes", 4'd5);
    test_read_bit(1'b0);
    test_read_bit(1'b1);
    test_stop_abort();
    test_busy_ignore();

    $display("tests %0d, checks %0d, failed checks %0d, assertion failures %0d",
             n_tests, n_checks, n_errors, i_i2c_rx_top.i_i2c_rx_sva.fail_cnt);
    if (n_errors == 0 && i_i2c_rx_top.i_i2c_rx_sva.fail_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- all.f
logic/i2c_rx_pkg.sv
logic/bus_line_sampler.sv
logic/bus_rx_flow.sv
logic/rx_sequencer.sv
logic/i2c_rx_top.sv
testbench/i2c_rx_sva.sv
testbench/i2c_rx_tb.sv
